/* Makefile */
TOP = ApLineTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+verilog
verilog/dekatronPkg.sv
verilog/CounterIf.sv
verilog/DekatronCounter.sv
verilog/DataRam.sv
verilog/ApLine.sv
testbench/ClockGen.sv
testbench/ApLineTb.sv

/* testbench/ApLineTb.sv */
`timescale 1ns/100ps

module ApLineTb;

    localparam int NUM_OPS   = 300;
    localparam int DIRECTED  = 3;
    localparam int RESET_CYC = 16;
    localparam int OP_BOUND  = 5 * 40 + 10;   // five decades at 40 cycles per strobe
    localparam int LIMIT     = (NUM_OPS + DIRECTED) * OP_BOUND + RESET_CYC + 4;

    logic                Clk;
    logic                Rst_n;
    logic                hsClk;
    logic                ApRequest;
    logic                DataRequest;
    logic                Dec;
    logic                Ready;
    logic                ApZero;
    logic                DataZero;
    dekatronPkg::apAddrT Address;
    dekatronPkg::dataT   Data;

    int ptr;              // model pointer 0..99999
    int cells [1000];
    int cycles;
    int passCount;
    int failCount;

    ClockGen #(.PERIOD_NS(100)) clockGen (.Clk(Clk));

    ApLine u_ApLine (
        .Clk         (Clk),
        .Rst_n       (Rst_n),
        .hsClk       (hsClk),
        .ApRequest   (ApRequest),
        .DataRequest (DataRequest),
        .Dec         (Dec),
        .Ready       (Ready),
        .ApZero      (ApZero),
        .DataZero    (DataZero),
        .Address     (Address),
        .Data        (Data)
    );

    // ####################################################################
    // decimal to BCD
    // ####################################################################

    function automatic dekatronPkg::apAddrT addrBcd(input int value);
        dekatronPkg::apAddrT result;
        int v;
        result = '0;
        v = value;
        for (int d = 0; d < 5; d++) begin
            result[d*4 +: 4] = 4'(v % 10);   // units digit lowest
            v = v / 10;
        end
        return result;
    endfunction

    function automatic dekatronPkg::dataT dataBcd(input int value);
        dekatronPkg::dataT result;
        int v;
        result = '0;
        v = value;
        for (int d = 0; d < 3; d++) begin
            result[d*4 +: 4] = 4'(v % 10);
            v = v / 10;
        end
        return result;
    endfunction

    // ####################################################################
    // compare tasks
    // ####################################################################

    task automatic checkAddr(input string name, input dekatronPkg::apAddrT expected,
                             input dekatronPkg::apAddrT actual);
        if (actual === expected) begin
            passCount++;
        end else begin
            failCount++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkData(input string name, input dekatronPkg::dataT expected,
                             input dekatronPkg::dataT actual);
        if (actual === expected) begin
            passCount++;
        end else begin
            failCount++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            passCount++;
        end else begin
            failCount++;
            $display("FAILED %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic compareAll(input string name);
        checkAddr({name, " address"}, addrBcd(ptr), Address);
        checkData({name, " data"}, dataBcd(cells[ptr % 1000]), Data);
        checkFlag({name, " ApZero"}, ptr == 0, ApZero);
        checkFlag({name, " DataZero"}, cells[ptr % 1000] == 0, DataZero);
    endtask

    task automatic reportTest(input string name, input int failsAtStart);
        if (failCount == failsAtStart) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, failCount - failsAtStart);
        end
    endtask

    // ####################################################################
    // stimulus
    // ####################################################################

    // one falling edge and a new strobe
    task automatic nextCycle();
        @(negedge Clk);
        cycles++;
        hsClk = (($urandom % 2) == 1);   // strobe in about half the cycles
    endtask

    task automatic runOp(input logic isAp, input logic down, input string name);
        int idx;
        Dec         = down;   // held until Ready is back
        ApRequest   = isAp;
        DataRequest = ~isAp;
        nextCycle();
        ApRequest   = 1'b0;
        DataRequest = 1'b0;
        checkFlag({name, " Ready drop"}, 1'b0, Ready);
        while (Ready !== 1'b1) begin
            nextCycle();
        end
        Dec = 1'b0;
        if (isAp) begin
            ptr = down ? (ptr + 99999) % 100000 : (ptr + 1) % 100000;
        end else begin
            idx        = ptr % 1000;
            cells[idx] = down ? (cells[idx] + 999) % 1000 : (cells[idx] + 1) % 1000;
        end
        compareAll(name);
    endtask

    // cycle budget watchdog
    initial begin
        wait (cycles >= LIMIT);
        $display("Ready never returned, run stopped after %0d cycles", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int   mark;
        int   pick;
        logic isAp;
        logic down;
        Rst_n       = 1'b0;
        hsClk       = 1'b0;
        ApRequest   = 1'b0;
        DataRequest = 1'b0;
        Dec         = 1'b0;
        ptr         = 0;
        cycles      = 0;
        passCount   = 0;
        failCount   = 0;
        for (int i = 0; i < 1000; i++) begin
            cells[i] = 0;
        end
        void'($urandom(9359));

        repeat (RESET_CYC) begin
            nextCycle();
        end
        Rst_n = 1'b1;
        nextCycle();   // Ready one cycle after release

        mark = failCount;
        checkFlag("reset Ready", 1'b1, Ready);
        compareAll("reset");
        reportTest("reset", mark);

        // both counters wrap downward from zero
        mark = failCount;
        runOp(1'b0, 1'b1, "cell down from 000");
        runOp(1'b1, 1'b1, "pointer down from 0");
        runOp(1'b1, 1'b0, "pointer back to 0");
        reportTest("wrap", mark);

        mark = failCount;
        for (int i = 0; i < NUM_OPS; i++) begin
            pick = int'($urandom % 100);
            isAp = (pick < 50);
            pick = int'($urandom % 100);
            down = (pick < 35);   // increments win
            runOp(isAp, down, $sformatf("op %0d", i));
        end
        reportTest("random stream", mark);

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/ClockGen.sv */
`timescale 1ns/100ps

module ClockGen #(
    parameter int PERIOD_NS = 100
)(
    output logic Clk
);

    // free running, starts low
    initial begin
        Clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) Clk = ~Clk;
        end
    end

endmodule

/* verilog/ApLine.sv */
`timescale 1ns/100ps
`include "dekatron_macros.svh"

module ApLine (
    input  logic                Clk,
    input  logic                Rst_n,
    input  logic                hsClk,
    input  logic                ApRequest,
    input  logic                DataRequest,
    input  logic                Dec,
    output logic                Ready,
    output logic                ApZero,
    output logic                DataZero,
    output dekatronPkg::apAddrT Address,
    output dekatronPkg::dataT   Data
);

    CounterIf #(.countT(dekatronPkg::apAddrT)) apBus ();
    CounterIf #(.countT(dekatronPkg::dataT))   dataBus ();

    dekatronPkg::lineStateT state;
    logic                   apReq;
    logic                   dataReq;
    logic                   dataSet;
    logic                   we;
    logic                   memLock;   // cell held in the data counter
    logic                   accept;
    dekatronPkg::dataT      ramOut;

    // ######################################################################
    // counters and data store
    // ######################################################################

    DekatronCounter #(
        .countT(dekatronPkg::apAddrT)
    ) apCounter (
        .Clk   (Clk),
        .Rst_n (Rst_n),
        .hsClk (hsClk),
        .bus   (apBus.cnt)
    );

    DekatronCounter #(
        .countT(dekatronPkg::dataT)
    ) dataCounter (
        .Clk   (Clk),
        .Rst_n (Rst_n),
        .hsClk (hsClk),
        .bus   (dataBus.cnt)
    );

    DataRam dataRam (
        .Clk     (Clk),
        .Address (apBus.Out[`RAM_ADDR_BITS-1:0]),   // low three digits
        .In      (dataBus.Out),
        .Out     (ramOut),
        .WE      (we)
    );

    // pointer is only ever stepped
    assign apBus.Request = apReq;
    assign apBus.Dec     = Dec;
    assign apBus.Set     = 1'b0;
    assign apBus.In      = '0;

    assign dataBus.Request = dataReq;
    assign dataBus.Dec     = Dec;
    assign dataBus.Set     = dataSet;
    assign dataBus.In      = ramOut;

    // ######################################################################
    // load / store / count controller
    // ######################################################################

    assign accept = (state == dekatronPkg::IDLE) & apBus.Ready & dataBus.Ready;
    assign Ready  = accept & ~ApRequest & ~DataRequest;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state   <= dekatronPkg::IDLE;
            apReq   <= 1'b0;
            dataReq <= 1'b0;
            dataSet <= 1'b0;
            we      <= 1'b0;
            memLock <= 1'b0;
        end else begin
            case (state)
                dekatronPkg::IDLE: begin
                    if (accept && ApRequest) begin
                        if (memLock) begin
                            state <= dekatronPkg::STORE;   // write back first
                            we    <= 1'b1;
                        end else begin
                            state <= dekatronPkg::COUNT;
                            apReq <= 1'b1;
                        end
                    end else if (accept && DataRequest) begin
                        dataReq <= 1'b1;
                        if (!memLock) begin
                            state   <= dekatronPkg::LOAD;   // fetch cell first
                            dataSet <= 1'b1;
                        end else begin
                            state <= dekatronPkg::COUNT;
                        end
                    end
                end
                dekatronPkg::STORE: begin
                    we      <= 1'b0;
                    memLock <= 1'b0;
                    apReq   <= 1'b1;
                    state   <= dekatronPkg::COUNT;
                end
                dekatronPkg::LOAD: begin
                    if (dataReq) begin
                        dataReq <= 1'b0;   // load pulse sent
                        dataSet <= 1'b0;
                        memLock <= 1'b1;
                    end else if (dataBus.Ready) begin
                        dataReq <= 1'b1;   // now step the cached cell
                        state   <= dekatronPkg::COUNT;
                    end
                end
                dekatronPkg::COUNT: begin
                    apReq   <= 1'b0;
                    dataReq <= 1'b0;
                    if (!apReq && !dataReq && apBus.Ready && dataBus.Ready) begin
                        state <= dekatronPkg::IDLE;
                    end
                end
                default: begin
                    state <= dekatronPkg::IDLE;
                end
            endcase
        end
    end

    // ######################################################################
    // outputs
    // ######################################################################

    assign Address  = apBus.Out;
    assign ApZero   = apBus.Zero;
    assign DataZero = memLock ? dataBus.Zero : (ramOut == '0);   // follows the shown cell
    assign Data     = memLock ? dataBus.Out : ramOut;   // cached value wins

endmodule

/* verilog/CounterIf.sv */
`timescale 1ns/100ps

interface CounterIf #(
    parameter type countT = dekatronPkg::dataT
);

    logic  Request;   // one-cycle pulse
    logic  Dec;       // direction, held for the whole step
    logic  Set;       // load In instead of stepping
    countT In;
    logic  Ready;
    countT Out;
    logic  Zero;

    modport ctrl (
        output Request,
        output Dec,
        output Set,
        output In,
        input  Ready,
        input  Out,
        input  Zero
    );

    modport cnt (
        input  Request,
        input  Dec,
        input  Set,
        input  In,
        output Ready,
        output Out,
        output Zero
    );

endinterface

/* verilog/DataRam.sv */
`timescale 1ns/100ps
`include "dekatron_macros.svh"

module DataRam (
    input  logic                      Clk,
    input  logic [`RAM_ADDR_BITS-1:0] Address,
    input  dekatronPkg::dataT         In,
    output dekatronPkg::dataT         Out,
    input  logic                      WE
);

    localparam int ROWS = 1 << `RAM_ADDR_BITS;

    dekatronPkg::dataT mem [ROWS];

    // every cell starts at 000
    initial begin
        for (int i = 0; i < ROWS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge Clk) begin
        if (WE) begin
            mem[Address] <= In;
        end
    end

    assign Out = mem[Address];   // async read

endmodule

/* verilog/DekatronCounter.sv */
`timescale 1ns/100ps
`include "dekatron_macros.svh"

module DekatronCounter #(
    parameter type countT = dekatronPkg::dataT
)(
    input logic   Clk,
    input logic   Rst_n,
    input logic   hsClk,
    CounterIf.cnt bus
);

    localparam int DIGITS = $bits(countT) / `DEKATRON_WIDTH;
    localparam int IDX_W = (DIGITS > 1) ? $clog2(DIGITS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DIGITS - 1);

    countT            count;
    logic             busy;        // ripple in progress
    logic             loadCycle;   // Set load took this cycle
    logic [IDX_W-1:0] digitIdx;    // decade being stepped
    logic             decLatch;

    dekatronPkg::digitT curDigit;
    dekatronPkg::digitT nextDigit;
    logic               wrap;

    // ######################################################################
    // digit arithmetic
    // ######################################################################

    assign curDigit = count[digitIdx*`DEKATRON_WIDTH +: `DEKATRON_WIDTH];

    always_comb begin
        if (decLatch) begin
            wrap = (curDigit == dekatronPkg::digitT'(0));   // 0 -> 9 borrows
            if (wrap) begin
                nextDigit = dekatronPkg::digitT'(9);
            end else begin
                nextDigit = curDigit - dekatronPkg::digitT'(1);
            end
        end else begin
            wrap = (curDigit == dekatronPkg::digitT'(9));   // 9 -> 0 carries
            if (wrap) begin
                nextDigit = dekatronPkg::digitT'(0);
            end else begin
                nextDigit = curDigit + dekatronPkg::digitT'(1);
            end
        end
    end

    // ######################################################################
    // count register and ripple control
    // ######################################################################

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            count     <= '0;
            busy      <= 1'b0;
            loadCycle <= 1'b0;
            digitIdx  <= '0;
            decLatch  <= 1'b0;
        end else begin
            loadCycle <= 1'b0;
            if (bus.Request && bus.Ready) begin
                if (bus.Set) begin
                    count     <= bus.In;   // whole value at once
                    loadCycle <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    digitIdx <= '0;        // start at the units decade
                    decLatch <= bus.Dec;
                end
            end else if (busy && hsClk) begin
                count[digitIdx*`DEKATRON_WIDTH +: `DEKATRON_WIDTH] <= nextDigit;
                if (wrap && (digitIdx != LAST_IDX)) begin
                    digitIdx <= digitIdx + 1'b1;   // carry moves up next strobe
                end else begin
                    busy <= 1'b0;   // top digit wrap ends it too
                end
            end
        end
    end

    assign bus.Ready = ~busy & ~loadCycle;
    assign bus.Out   = count;
    assign bus.Zero  = (count == '0);

endmodule

/* verilog/dekatronPkg.sv */
`include "dekatron_macros.svh"

package dekatronPkg;

    // one BCD digit
    typedef logic [`DEKATRON_WIDTH-1:0] digitT;

    // five packed digits, lowest digit in the low bits
    typedef logic [`AP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] apAddrT;

    // three packed digits
    typedef logic [`DATA_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] dataT;

    // controller state, one-hot
    typedef enum logic [3:0] {
        IDLE  = 4'b0001,
        LOAD  = 4'b0010,
        STORE = 4'b0100,
        COUNT = 4'b1000
    } lineStateT;

endpackage

/* verilog/dekatron_macros.svh */
`ifndef DEKATRON_MACROS_SVH
`define DEKATRON_MACROS_SVH

// bits per BCD digit
`define DEKATRON_WIDTH 4

// digits in the address pointer
`define AP_DEKATRON_NUM 5

// digits in one data cell
`define DATA_DEKATRON_NUM 3

// RAM row index taken from the low three pointer digits as raw bits
`define RAM_ADDR_BITS 12

`endif
